// File: hw/vmul_cfg.svh
`ifndef VMUL_CFG_SVH
`define VMUL_CFG_SVH

// operand and result vector width
`define VMUL_DATA_W 64
`define VMUL_ADDR_W 32

// one extended 16-bit half plus sign
`define VMUL_OPND_W 17
`define VMUL_PROD_W 34

// slots in the downstream result buffer
`define VMUL_CREDITS 4

// operand select, multiply, result select
`define VMUL_LATENCY 3

`endif

// File: hw/vmul_pkg.sv
`include "vmul_cfg.svh"

package vmul_pkg;

	typedef logic [`VMUL_DATA_W-1:0] vec_t;
	typedef logic [`VMUL_ADDR_W-1:0] addr_t;

	typedef logic signed [`VMUL_OPND_W-1:0] opnd_t;
	typedef logic signed [`VMUL_PROD_W-1:0] prod_t;
	typedef logic [`VMUL_DATA_W-1:0] wide_t;

	typedef logic [$clog2(`VMUL_CREDITS+1)-1:0] credit_t;

	// element width, sew_64 gives a zero result
	typedef enum logic [1:0] {
		sew_8 = 2'd0,
		sew_16 = 2'd1,
		sew_32 = 2'd2,
		sew_64 = 2'd3
	} sew_e;

	typedef enum logic [1:0] {
		op_mul = 2'd0,
		op_mulh = 2'd1,
		op_mulhu = 2'd2,
		op_mulhsu = 2'd3
	} op_e;

endpackage

// File: hw/vmul_operand_select.sv
`include "vmul_cfg.svh"

module vmul_operand_select (
	input  logic            clk,
	input  logic            rst,
	input  vmul_pkg::vec_t  vec0,
	input  vmul_pkg::vec_t  vec1,
	input  vmul_pkg::sew_e  sew,
	input  vmul_pkg::op_e   op,
	output vmul_pkg::opnd_t u0_a0,
	output vmul_pkg::opnd_t u0_a1,
	output vmul_pkg::opnd_t u0_b0,
	output vmul_pkg::opnd_t u0_b1,
	output vmul_pkg::opnd_t u1_a0,
	output vmul_pkg::opnd_t u1_a1,
	output vmul_pkg::opnd_t u1_b0,
	output vmul_pkg::opnd_t u1_b1,
	output vmul_pkg::opnd_t u2_a0,
	output vmul_pkg::opnd_t u2_a1,
	output vmul_pkg::opnd_t u2_b0,
	output vmul_pkg::opnd_t u2_b1,
	output vmul_pkg::opnd_t u3_a0,
	output vmul_pkg::opnd_t u3_a1,
	output vmul_pkg::opnd_t u3_b0,
	output vmul_pkg::opnd_t u3_b1
);

	// slot = unit*2 + product index
	vmul_pkg::opnd_t a_n [8];
	vmul_pkg::opnd_t b_n [8];
	vmul_pkg::opnd_t a_q [8];
	vmul_pkg::opnd_t b_q [8];
	logic            sgn_a;
	logic            sgn_b;

	function automatic vmul_pkg::opnd_t ext8(input logic [7:0] x, input logic sgn);
		ext8 = {{(`VMUL_OPND_W-8){sgn & x[7]}}, x};
	endfunction

	function automatic vmul_pkg::opnd_t ext16(input logic [15:0] x, input logic sgn);
		ext16 = {{(`VMUL_OPND_W-16){sgn & x[15]}}, x};
	endfunction

	// low half does not depend on signedness
	assign sgn_a = (op == vmul_pkg::op_mulh) || (op == vmul_pkg::op_mulhsu);
	assign sgn_b = (op == vmul_pkg::op_mulh);

	always_comb begin
		for (int s = 0; s < 8; s++) begin
			a_n[s] = '0;
			b_n[s] = '0;
		end
		case (sew)
			vmul_pkg::sew_8: begin
				// lane i lands in slot 7-i
				for (int s = 0; s < 8; s++) begin
					a_n[s] = ext8(vec0[8*(7-s) +: 8], sgn_a);
					b_n[s] = ext8(vec1[8*(7-s) +: 8], sgn_b);
				end
			end
			vmul_pkg::sew_16: begin
				a_n[7] = ext16(vec0[15:0], sgn_a);
				a_n[6] = ext16(vec0[31:16], sgn_a);
				a_n[1] = ext16(vec0[47:32], sgn_a);
				a_n[0] = ext16(vec0[63:48], sgn_a);
				b_n[7] = ext16(vec1[15:0], sgn_b);
				b_n[6] = ext16(vec1[31:16], sgn_b);
				b_n[1] = ext16(vec1[47:32], sgn_b);
				b_n[0] = ext16(vec1[63:48], sgn_b);
			end
			vmul_pkg::sew_32: begin
				// lane 0 on unit 3, lane 1 on unit 0, lower halves unsigned
				a_n[7] = ext16(vec0[31:16], sgn_a);
				a_n[6] = ext16(vec0[15:0], 1'b0);
				a_n[1] = ext16(vec0[63:48], sgn_a);
				a_n[0] = ext16(vec0[47:32], 1'b0);
				b_n[7] = ext16(vec1[31:16], sgn_b);
				b_n[6] = ext16(vec1[15:0], 1'b0);
				b_n[1] = ext16(vec1[63:48], sgn_b);
				b_n[0] = ext16(vec1[47:32], 1'b0);
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < 8; s++) begin
				a_q[s] <= '0;
				b_q[s] <= '0;
			end
		end else begin
			a_q <= a_n;
			b_q <= b_n;
		end
	end

	assign u0_a0 = a_q[0];
	assign u0_a1 = a_q[1];
	assign u1_a0 = a_q[2];
	assign u1_a1 = a_q[3];
	assign u2_a0 = a_q[4];
	assign u2_a1 = a_q[5];
	assign u3_a0 = a_q[6];
	assign u3_a1 = a_q[7];
	assign u0_b0 = b_q[0];
	assign u0_b1 = b_q[1];
	assign u1_b0 = b_q[2];
	assign u1_b1 = b_q[3];
	assign u2_b0 = b_q[4];
	assign u2_b1 = b_q[5];
	assign u3_b0 = b_q[6];
	assign u3_b1 = b_q[7];

endmodule

// File: hw/vmul_mult32.sv
`include "vmul_cfg.svh"

module vmul_mult32 (
	input  logic            clk,
	input  logic            rst,
	input  vmul_pkg::opnd_t a0,
	input  vmul_pkg::opnd_t a1,
	input  vmul_pkg::opnd_t b0,
	input  vmul_pkg::opnd_t b1,
	output vmul_pkg::prod_t p0,
	output vmul_pkg::prod_t p1,
	output vmul_pkg::wide_t wide
);

	vmul_pkg::prod_t pp00;
	vmul_pkg::prod_t pp11;
	vmul_pkg::prod_t pp10;
	vmul_pkg::prod_t pp01;
	vmul_pkg::wide_t wide_n;

	function automatic vmul_pkg::wide_t sext(input vmul_pkg::prod_t p);
		sext = {{(`VMUL_DATA_W-`VMUL_PROD_W){p[`VMUL_PROD_W-1]}}, p};
	endfunction

	assign pp00 = vmul_pkg::prod_t'(a0) * vmul_pkg::prod_t'(b0);
	assign pp11 = vmul_pkg::prod_t'(a1) * vmul_pkg::prod_t'(b1);
	assign pp10 = vmul_pkg::prod_t'(a1) * vmul_pkg::prod_t'(b0);
	assign pp01 = vmul_pkg::prod_t'(a0) * vmul_pkg::prod_t'(b1);

	// {a1,a0} * {b1,b0}, only the low 64 bits are kept
	assign wide_n = (sext(pp11) << 32) + (sext(pp10) << 16) + (sext(pp01) << 16) + sext(pp00);

	always_ff @(posedge clk) begin
		if (rst) begin
			p0 <= '0;
			p1 <= '0;
			wide <= '0;
		end else begin
			p0 <= pp00;
			p1 <= pp11;
			wide <= wide_n;
		end
	end

endmodule

// File: hw/vmul_result_select.sv
module vmul_result_select (
	input  logic            clk,
	input  logic            rst,
	input  vmul_pkg::prod_t u0_p0,
	input  vmul_pkg::prod_t u0_p1,
	input  vmul_pkg::prod_t u1_p0,
	input  vmul_pkg::prod_t u1_p1,
	input  vmul_pkg::prod_t u2_p0,
	input  vmul_pkg::prod_t u2_p1,
	input  vmul_pkg::prod_t u3_p0,
	input  vmul_pkg::prod_t u3_p1,
	input  vmul_pkg::wide_t wide0,
	input  vmul_pkg::wide_t wide3,
	input  vmul_pkg::sew_e  sew,
	input  logic            high,
	output vmul_pkg::vec_t  vec
);

	vmul_pkg::vec_t vec_n;

	function automatic logic [7:0] pick8(input vmul_pkg::prod_t p, input logic hi);
		pick8 = hi ? p[15:8] : p[7:0];
	endfunction

	function automatic logic [15:0] pick16(input vmul_pkg::prod_t p, input logic hi);
		pick16 = hi ? p[31:16] : p[15:0];
	endfunction

	function automatic logic [31:0] pick32(input vmul_pkg::wide_t w, input logic hi);
		pick32 = hi ? w[63:32] : w[31:0];
	endfunction

	// lane 0 in the low bits, mirrors the slot order of operand select
	always_comb begin
		case (sew)
			vmul_pkg::sew_8: begin
				vec_n = {
					pick8(u0_p0, high),
					pick8(u0_p1, high),
					pick8(u1_p0, high),
					pick8(u1_p1, high),
					pick8(u2_p0, high),
					pick8(u2_p1, high),
					pick8(u3_p0, high),
					pick8(u3_p1, high)
				};
			end
			vmul_pkg::sew_16: begin
				vec_n = {
					pick16(u0_p0, high),
					pick16(u0_p1, high),
					pick16(u3_p0, high),
					pick16(u3_p1, high)
				};
			end
			vmul_pkg::sew_32: begin
				// unit 0 carries the upper lane
				vec_n = {pick32(wide0, high), pick32(wide3, high)};
			end
			default: begin
				vec_n = '0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			vec <= '0;
		end else begin
			vec <= vec_n;
		end
	end

endmodule

// File: hw/vmul_ctrl_pipe.sv
`include "vmul_cfg.svh"

module vmul_ctrl_pipe (
	input  logic            clk,
	input  logic            rst,
	input  logic            in_valid,
	input  vmul_pkg::sew_e  in_sew,
	input  vmul_pkg::op_e   in_op,
	input  vmul_pkg::addr_t in_addr,
	output vmul_pkg::sew_e  s2_sew,
	output logic            s2_high,
	output logic            out_valid,
	output vmul_pkg::addr_t out_addr
);

	logic            vld_q [1:`VMUL_LATENCY];
	vmul_pkg::addr_t addr_q [1:`VMUL_LATENCY];
	vmul_pkg::sew_e  s1_sew;
	logic            s1_high;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i <= `VMUL_LATENCY; i++) begin
				vld_q[i] <= 1'b0;
				addr_q[i] <= '0;
			end
			s1_sew <= vmul_pkg::sew_8;
			s1_high <= 1'b0;
			s2_sew <= vmul_pkg::sew_8;
			s2_high <= 1'b0;
		end else begin
			// sideband zeroed on idle cycles
			vld_q[1] <= in_valid;
			addr_q[1] <= in_valid ? in_addr : '0;
			s1_sew <= in_valid ? in_sew : vmul_pkg::sew_8;
			s1_high <= in_valid && (in_op != vmul_pkg::op_mul);
			s2_sew <= s1_sew;
			s2_high <= s1_high;
			for (int i = 2; i <= `VMUL_LATENCY; i++) begin
				vld_q[i] <= vld_q[i-1];
				addr_q[i] <= addr_q[i-1];
			end
		end
	end

	assign out_valid = vld_q[`VMUL_LATENCY];
	assign out_addr = addr_q[`VMUL_LATENCY];

	a_quiet_in_reset: assert property (@(posedge clk) rst |=> !out_valid)
		else $error("result valid while in reset");

endmodule

// File: hw/vmul_credit_gate.sv
`include "vmul_cfg.svh"

module vmul_credit_gate (
	input  logic clk,
	input  logic rst,
	input  logic in_valid,
	input  logic out_credit,
	output logic in_credit
);

	// pending: not yet granted, held: upstream owns, used: in pipe or consumer
	vmul_pkg::credit_t pending;
	vmul_pkg::credit_t held;
	vmul_pkg::credit_t used;
	logic              grant;

	assign grant = (pending != '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			pending <= vmul_pkg::credit_t'(`VMUL_CREDITS);
			held <= '0;
			used <= '0;
			in_credit <= 1'b0;
		end else begin
			// one grant per cycle
			in_credit <= grant;
			case ({grant, out_credit})
				2'b10: pending <= pending - 1'b1;
				2'b01: pending <= pending + 1'b1;
				default: begin
				end
			endcase
			case ({in_credit, in_valid})
				2'b10: held <= held + 1'b1;
				2'b01: held <= held - 1'b1;
				default: begin
				end
			endcase
			case ({in_valid, out_credit})
				2'b10: used <= used + 1'b1;
				2'b01: used <= used - 1'b1;
				default: begin
				end
			endcase
		end
	end

	a_spend_held: assert property (@(posedge clk) disable iff (rst) in_valid |-> held != '0)
		else $error("operation issued without a credit");

	a_pool_bound: assert property (@(posedge clk) disable iff (rst)
		int'(pending) + int'(held) + int'(in_credit) + int'(used) <= `VMUL_CREDITS)
		else $error("credit pool overrun");

endmodule

// File: hw/vmul_top.sv
module vmul_top (
	input  logic            clk,
	input  logic            rst,
	input  logic            in_valid,
	input  vmul_pkg::vec_t  in_vec0,
	input  vmul_pkg::vec_t  in_vec1,
	input  vmul_pkg::sew_e  in_sew,
	input  vmul_pkg::op_e   in_op,
	input  vmul_pkg::addr_t in_addr,
	output logic            in_credit,
	output logic            out_valid,
	output vmul_pkg::vec_t  out_vec,
	output vmul_pkg::addr_t out_addr,
	input  logic            out_credit
);

	vmul_pkg::opnd_t a0 [4];
	vmul_pkg::opnd_t a1 [4];
	vmul_pkg::opnd_t b0 [4];
	vmul_pkg::opnd_t b1 [4];
	vmul_pkg::prod_t p0 [4];
	vmul_pkg::prod_t p1 [4];
	vmul_pkg::wide_t wide0;
	vmul_pkg::wide_t wide3;
	vmul_pkg::sew_e  s2_sew;
	logic            s2_high;

	vmul_operand_select u_opnd (
		.clk   (clk),
		.rst   (rst),
		.vec0  (in_vec0),
		.vec1  (in_vec1),
		.sew   (in_sew),
		.op    (in_op),
		.u0_a0 (a0[0]),
		.u0_a1 (a1[0]),
		.u0_b0 (b0[0]),
		.u0_b1 (b1[0]),
		.u1_a0 (a0[1]),
		.u1_a1 (a1[1]),
		.u1_b0 (b0[1]),
		.u1_b1 (b1[1]),
		.u2_a0 (a0[2]),
		.u2_a1 (a1[2]),
		.u2_b0 (b0[2]),
		.u2_b1 (b1[2]),
		.u3_a0 (a0[3]),
		.u3_a1 (a1[3]),
		.u3_b0 (b0[3]),
		.u3_b1 (b1[3])
	);

	// only units 0 and 3 serve the 32-bit lanes
	vmul_mult32 u_mul0 (.clk(clk), .rst(rst), .a0(a0[0]), .a1(a1[0]), .b0(b0[0]), .b1(b1[0]),
		.p0(p0[0]), .p1(p1[0]), .wide(wide0));
	vmul_mult32 u_mul1 (.clk(clk), .rst(rst), .a0(a0[1]), .a1(a1[1]), .b0(b0[1]), .b1(b1[1]),
		.p0(p0[1]), .p1(p1[1]), .wide());
	vmul_mult32 u_mul2 (.clk(clk), .rst(rst), .a0(a0[2]), .a1(a1[2]), .b0(b0[2]), .b1(b1[2]),
		.p0(p0[2]), .p1(p1[2]), .wide());
	vmul_mult32 u_mul3 (.clk(clk), .rst(rst), .a0(a0[3]), .a1(a1[3]), .b0(b0[3]), .b1(b1[3]),
		.p0(p0[3]), .p1(p1[3]), .wide(wide3));

	vmul_ctrl_pipe u_ctrl (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_sew    (in_sew),
		.in_op     (in_op),
		.in_addr   (in_addr),
		.s2_sew    (s2_sew),
		.s2_high   (s2_high),
		.out_valid (out_valid),
		.out_addr  (out_addr)
	);

	vmul_result_select u_res (
		.clk   (clk),
		.rst   (rst),
		.u0_p0 (p0[0]),
		.u0_p1 (p1[0]),
		.u1_p0 (p0[1]),
		.u1_p1 (p1[1]),
		.u2_p0 (p0[2]),
		.u2_p1 (p1[2]),
		.u3_p0 (p0[3]),
		.u3_p1 (p1[3]),
		.wide0 (wide0),
		.wide3 (wide3),
		.sew   (s2_sew),
		.high  (s2_high),
		.vec   (out_vec)
	);

	vmul_credit_gate u_credit (
		.clk        (clk),
		.rst        (rst),
		.in_valid   (in_valid),
		.out_credit (out_credit),
		.in_credit  (in_credit)
	);

endmodule

// File: bench/vmul_tb.sv
`include "vmul_cfg.svh"

module vmul_tb;

	logic            clk;
	logic            rst;
	logic            in_valid;
	vmul_pkg::vec_t  in_vec0;
	vmul_pkg::vec_t  in_vec1;
	vmul_pkg::sew_e  in_sew;
	vmul_pkg::op_e   in_op;
	vmul_pkg::addr_t in_addr;
	logic            in_credit;
	logic            out_valid;
	vmul_pkg::vec_t  out_vec;
	vmul_pkg::addr_t out_addr;
	logic            out_credit;

	logic [31:0]     lfsr;
	int              cyc;
	int              credits;
	int              granted;
	int              returned;
	int              buffered;
	int              issued;
	vmul_pkg::vec_t  exp_vec [$];
	vmul_pkg::addr_t exp_addr [$];
	int              exp_cycle [$];

	vmul_top u_dut (
		.clk        (clk),
		.rst        (rst),
		.in_valid   (in_valid),
		.in_vec0    (in_vec0),
		.in_vec1    (in_vec1),
		.in_sew     (in_sew),
		.in_op      (in_op),
		.in_addr    (in_addr),
		.in_credit  (in_credit),
		.out_valid  (out_valid),
		.out_vec    (out_vec),
		.out_addr   (out_addr),
		.out_credit (out_credit)
	);

	always #5 clk = ~clk;

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("sim failed");
		$fatal(1, "stopped at time %0t", $time);
	endtask

	task automatic check_vec(input string name, input vmul_pkg::vec_t got,
		input vmul_pkg::vec_t exp);
		if (got !== exp) begin
			report_failure($sformatf("mismatch at %0t: %s got %h expected %h",
				$time, name, got, exp));
		end
	endtask

	task automatic check_addr(input string name, input vmul_pkg::addr_t got,
		input vmul_pkg::addr_t exp);
		if (got !== exp) begin
			report_failure($sformatf("mismatch at %0t: %s got %h expected %h",
				$time, name, got, exp));
		end
	endtask

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw(input int n, output logic [63:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[62:0], lfsr[0]};
		end
	endtask

	function automatic int lane_width(input vmul_pkg::sew_e sew);
		case (sew)
			vmul_pkg::sew_8: lane_width = 8;
			vmul_pkg::sew_16: lane_width = 16;
			default: lane_width = 32;
		endcase
	endfunction

	// all ones, most negative or most positive in random lanes
	task automatic add_corners(input vmul_pkg::sew_e sew, inout vmul_pkg::vec_t v);
		logic [63:0] pick;
		logic [63:0] mask;
		logic [63:0] lane;
		int          w;
		w = lane_width(sew);
		mask = (64'd1 << w) - 64'd1;
		for (int i = 0; i < 64 / w; i++) begin
			draw(2, pick);
			lane = (v >> (i * w)) & mask;
			case (pick[1:0])
				2'd1: lane = mask;
				2'd2: lane = 64'd1 << (w - 1);
				2'd3: lane = mask >> 1;
				default: begin
				end
			endcase
			v = (v & ~(mask << (i * w))) | (lane << (i * w));
		end
	endtask

	function automatic vmul_pkg::vec_t model(input vmul_pkg::vec_t a, input vmul_pkg::vec_t b,
		input vmul_pkg::sew_e sew, input vmul_pkg::op_e op);
		logic [63:0] mask;
		logic [63:0] x;
		logic [63:0] y;
		logic [63:0] prod;
		int          w;
		model = '0;
		if (sew == vmul_pkg::sew_64) begin
			return '0;
		end
		w = lane_width(sew);
		mask = (64'd1 << w) - 64'd1;
		for (int i = 0; i < 64 / w; i++) begin
			x = (a >> (i * w)) & mask;
			y = (b >> (i * w)) & mask;
			if ((op == vmul_pkg::op_mulh || op == vmul_pkg::op_mulhsu) && x[w-1]) begin
				x = x | ~mask;
			end
			if (op == vmul_pkg::op_mulh && y[w-1]) begin
				y = y | ~mask;
			end
			// low 64 bits of the double-width product are exact for w <= 32
			prod = x * y;
			if (op != vmul_pkg::op_mul) begin
				prod = prod >> w;
			end
			model = model | ((prod & mask) << (i * w));
		end
	endfunction

	// one clock: check results, count credits, then drive the next inputs
	task automatic step(input int issue_lvl, input int return_lvl);
		logic [63:0]    r;
		logic [63:0]    v0;
		logic [63:0]    v1;
		logic [63:0]    fld;
		vmul_pkg::sew_e sew;
		vmul_pkg::op_e  op;
		@(posedge clk);
		cyc++;
		in_valid <= 1'b0;
		out_credit <= 1'b0;
		if (out_valid === 1'b1) begin
			if (exp_vec.size() == 0) begin
				report_failure("result arrived with no operation in flight");
			end
			if (exp_cycle[0] != cyc) begin
				report_failure($sformatf("result at cycle %0d, expected at cycle %0d",
					cyc, exp_cycle[0]));
			end
			check_vec("out_vec", out_vec, exp_vec.pop_front());
			check_addr("out_addr", out_addr, exp_addr.pop_front());
			void'(exp_cycle.pop_front());
			buffered++;
		end else if (out_valid !== 1'b0) begin
			report_failure("out_valid is unknown");
		end else if (exp_cycle.size() != 0 && exp_cycle[0] <= cyc) begin
			report_failure("an expected result did not arrive on time");
		end
		if (in_credit === 1'b1) begin
			credits++;
			granted++;
			if (granted > returned + `VMUL_CREDITS) begin
				report_failure("more credits granted than returned plus the initial pool");
			end
		end
		if (buffered > 0) begin
			draw(4, r);
			if (int'(r[3:0]) < return_lvl) begin
				out_credit <= 1'b1;
				buffered--;
				returned++;
			end
		end
		if (credits > 0) begin
			draw(4, r);
			if (int'(r[3:0]) < issue_lvl) begin
				draw(64, v0);
				draw(64, v1);
				draw(2, fld);
				sew = vmul_pkg::sew_e'(fld[1:0]);
				draw(2, fld);
				op = vmul_pkg::op_e'(fld[1:0]);
				draw(1, fld);
				if (fld[0] && sew != vmul_pkg::sew_64) begin
					add_corners(sew, v0);
					add_corners(sew, v1);
				end
				draw(32, fld);
				in_valid <= 1'b1;
				in_vec0 <= v0;
				in_vec1 <= v1;
				in_sew <= sew;
				in_op <= op;
				in_addr <= fld[31:0];
				exp_vec.push_back(model(v0, v1, sew, op));
				exp_addr.push_back(fld[31:0]);
				exp_cycle.push_back(cyc + 1 + `VMUL_LATENCY);
				credits--;
				issued++;
			end
		end
	endtask

	task automatic drain(input int limit);
		for (int t = 0; exp_vec.size() != 0 || buffered != 0; t++) begin
			if (t == limit) begin
				report_failure("pipeline did not drain in time");
			end
			step(0, 16);
		end
	endtask

	initial begin
		logic [63:0] r;
		int          hold;
		logic        hold_on;
		clk = 1'b0;
		rst = 1'b1;
		in_valid = 1'b0;
		in_vec0 = '0;
		in_vec1 = '0;
		in_sew = vmul_pkg::sew_8;
		in_op = vmul_pkg::op_mul;
		in_addr = '0;
		out_credit = 1'b0;
		lfsr = 32'h3035db9f;
		cyc = 0;
		credits = 0;
		granted = 0;
		returned = 0;
		buffered = 0;
		issued = 0;
		hold = 0;
		hold_on = 1'b0;
		for (int i = 0; i < 4; i++) begin
			@(posedge clk);
			if (i > 0 && (out_valid !== 1'b0 || in_credit !== 1'b0)) begin
				report_failure("outputs active during reset");
			end
		end
		rst <= 1'b0;

		// initial pool, then silence without returns
		step(0, 0);
		step(0, 0);
		if (credits != 1) begin
			report_failure("no credit in the first cycle after reset");
		end
		for (int t = 0; credits < `VMUL_CREDITS; t++) begin
			if (t == 20) begin
				report_failure("initial credits were not all granted");
			end
			step(0, 0);
		end
		repeat (10) step(0, 0);
		if (credits != `VMUL_CREDITS) begin
			report_failure("credit count wrong after the initial pool");
		end

		// back to back on the whole pool
		repeat (`VMUL_CREDITS) step(16, 0);
		drain(100);

		issued = 0;
		for (int t = 0; issued < 2000; t++) begin
			if (t == 100000) begin
				report_failure("random traffic stalled");
			end
			if (hold == 0) begin
				draw(1, r);
				hold_on = r[0];
				draw(6, r);
				hold = int'(r[5:0]) + 1;
			end
			hold--;
			step(12, hold_on ? 0 : 8);
		end
		drain(1000);

		// every returned credit comes back as a grant
		for (int t = 0; credits < `VMUL_CREDITS; t++) begin
			if (t == 20) begin
				report_failure("returned credits were not granted again");
			end
			step(0, 0);
		end

		$display("sim passed");
		$finish;
	end

endmodule

// File: build.f
+incdir+hw
hw/vmul_pkg.sv
hw/vmul_operand_select.sv
hw/vmul_mult32.sv
hw/vmul_result_select.sv
hw/vmul_ctrl_pipe.sv
hw/vmul_credit_gate.sv
hw/vmul_top.sv
bench/vmul_tb.sv

// File: run.sh
#!/bin/sh
# build and run the vmul testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module vmul_tb -f build.f \
	-Mdir obj_dir -o vmul_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "build failed"
	exit 1
fi

./obj_dir/vmul_sim > sim.log 2>&1
status=$?
cat sim.log

if grep -q "sim failed" sim.log; then
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
exit 0
